// ==== Makefile ====
# Verilator build and run of the mbCore testbench

VERILATOR ?= verilator
TOP       ?= mbCore_tb
FILELIST  ?= mbcore.f
HEADERS   ?= mbcore_config.svh
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== mbCore.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbcore_config.svh"

module mbCore
  import mbcore_pkg::*;
(
  input  logic                   gclk,
  input  logic                   arstN,
  input  logic                   stepEn,
  input  logic                   instrValid,
  input  logic [`MB_DATA_W-1:0]  instr,
  output logic                   wbValid,
  output logic [`MB_REG_AW-1:0]  wbReg,
  output logic [`MB_DATA_W-1:0]  wbData,
  output logic                   stValid,
  output logic [`MB_DMEM_AW-1:0] stAddr,
  output logic [`MB_DATA_W-1:0]  stData
);

  logic [`MB_REG_AW-1:0] rdAddrA;
  logic [`MB_REG_AW-1:0] rdAddrB;
  logic [`MB_REG_AW-1:0] rdAddrD;
  logic [`MB_DATA_W-1:0] rdDataA;
  logic [`MB_DATA_W-1:0] rdDataB;
  logic [`MB_DATA_W-1:0] rdDataD;
  logic                  wrEn;
  logic [`MB_REG_AW-1:0] wrAddr;
  logic [`MB_DATA_W-1:0] wrData;
  decCtrlS               dec;
  exeResS                exe;
  fwdS                   exeDst;
  fwdS                   resFwd;
  fwdS                   lateFwd;

  mbDecodeCtrl u_decode (
    .gclk(gclk), .arstN(arstN), .stepEn(stepEn),
    .instrValid(instrValid), .instr(instr),
    .exeDst(exeDst), .resDst(resFwd),  // Result value doubles as its destination
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdAddrD(rdAddrD),
    .rdDataA(rdDataA), .rdDataB(rdDataB), .rdDataD(rdDataD),
    .dec(dec)
  );

  mbRegFile u_regFile (
    .gclk(gclk), .arstN(arstN),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdAddrD(rdAddrD),
    .rdDataA(rdDataA), .rdDataB(rdDataB), .rdDataD(rdDataD),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

  mbExecute u_execute (
    .gclk(gclk), .arstN(arstN), .stepEn(stepEn),
    .dec(dec), .resFwd(resFwd), .lateFwd(lateFwd),
    .exeDst(exeDst), .exe(exe)
  );

  mbResult u_result (
    .gclk(gclk), .arstN(arstN), .stepEn(stepEn), .exe(exe),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .resFwd(resFwd), .lateFwd(lateFwd),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .stValid(stValid), .stAddr(stAddr), .stData(stData)
  );

endmodule

`default_nettype wire

// ==== mbCore_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbcore_config.svh"

module mbCore_tb;

  localparam int clkPeriod = 20;

  typedef struct packed {
    logic                  isStore;
    logic [31:0]           key;  // Register number or word address
    logic [`MB_DATA_W-1:0] val;
  } expS;

  logic                   gclk;
  logic                   arstN;
  logic                   stepEn;
  logic                   instrValid;
  logic [`MB_DATA_W-1:0]  instr;
  logic                   wbValid;
  logic [`MB_REG_AW-1:0]  wbReg;
  logic [`MB_DATA_W-1:0]  wbData;
  logic                   stValid;
  logic [`MB_DMEM_AW-1:0] stAddr;
  logic [`MB_DATA_W-1:0]  stData;

  logic [`MB_DATA_W-1:0] prog [$];
  expS                   expAll [$];
  expS                   expQ [$];
  logic [31:0]           rngState;
  int                    errors;
  int                    checks;
  int                    testsRun;
  int                    testsFailed;
  int                    enEdges;  // Enabled edges since the first accepted instruction
  logic                  started;

  mbCore u_dut (
    .gclk(gclk), .arstN(arstN), .stepEn(stepEn),
    .instrValid(instrValid), .instr(instr),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .stValid(stValid), .stAddr(stAddr), .stData(stData)
  );

  initial begin
    gclk = 1'b0;
    forever #(clkPeriod / 2) gclk = ~gclk;
  end

  initial begin
    #(clkPeriod * 20000);
    $display("Simulation ran too long and was stopped by the watchdog");
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic loadTests();
    int                fd;
    int                n;
    logic [7:0]        kind;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [8*128-1:0]  rest;
    expS               e;
    bit                done;
    fd = $fopen("mbcore_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open mbcore_tests.txt");
      errors++;
    end else begin
      done = 1'b0;
      while (!done) begin
        n = $fscanf(fd, " %c", kind);
        if (n != 1) begin
          done = 1'b1;
        end else if (kind == "#") begin
          n = $fgets(rest, fd);  // Comment line
        end else if (kind == "I") begin
          n = $fscanf(fd, "%h", a);
          prog.push_back(a);
        end else if (kind == "W" || kind == "S") begin
          n = $fscanf(fd, "%h %h", a, b);
          e.isStore = (kind == "S");
          e.key     = a;
          e.val     = b;
          expAll.push_back(e);
        end else begin
          $display("Test file has a line of unknown kind");
          errors++;
          n = $fgets(rest, fd);
        end
      end
      $fclose(fd);
    end
    if (prog.size() == 0) begin
      $display("Test file gave no instructions");
      errors++;
    end
  endtask

  task automatic checkEvent(input bit isStore, input logic [31:0] key,
                            input logic [`MB_DATA_W-1:0] val);
    expS e;
    checks++;
    if (expQ.size() == 0) begin
      $display("Unexpected %s event at %0t with nothing left to expect",
               isStore ? "store" : "writeback", $time);
      errors++;
    end else begin
      e = expQ.pop_front();
      assert (e.isStore == isStore && e.key == key && e.val == val) else begin
        $display("CHECK FAILED at %0t: got %s %0h = %h, expected %s %0h = %h", $time,
                 isStore ? "store" : "wb", key, val, e.isStore ? "store" : "wb",
                 e.key, e.val);
        errors++;
      end
    end
  endtask

  // Count enabled edges once the first instruction goes in
  always @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      enEdges = 0;
      started = 1'b0;
    end else if (stepEn && (started || instrValid)) begin
      started = 1'b1;
      enEdges++;
    end
  end

  // Sample mid-way between the falling and the next rising edge
  always @(negedge gclk) begin
    #(clkPeriod / 4);
    if (arstN && (wbValid || stValid)) begin
      checks++;
      assert (stepEn && enEdges >= 2) else begin
        $display("CHECK FAILED at %0t: event with stepEn %b after %0d enabled edges",
                 $time, stepEn, enEdges);
        errors++;
      end
      if (wbValid) checkEvent(1'b0, 32'(wbReg), wbData);
      if (stValid) checkEvent(1'b1, 32'(stAddr), stData);
    end
  end

  task automatic driveStep(input bit withHolds);
    rngState = xorshift32(rngState);
    stepEn   = withHolds ? (rngState[1:0] != 2'b00) : 1'b1;  // Hold about one edge in four
  endtask

  task automatic applyReset();
    @(negedge gclk);
    arstN      = 1'b0;
    stepEn     = 1'b0;
    instrValid = 1'b0;
    repeat (3) @(posedge gclk);
    @(negedge gclk);
    arstN = 1'b1;
  endtask

  task automatic idleQuiet();
    repeat (5) begin
      @(negedge gclk);
      stepEn     = 1'b1;
      instrValid = 1'b0;
      #(clkPeriod / 4);
      checks++;
      assert (!wbValid && !stValid) else begin
        $display("CHECK FAILED at %0t: event from an empty pipeline", $time);
        errors++;
      end
    end
  endtask

  task automatic runProgram(input bit withHolds);
    int idx;
    int waited;
    idx    = 0;
    waited = 0;
    expQ   = expAll;
    while (idx < prog.size() && waited < prog.size() * 8 + 20) begin
      @(negedge gclk);
      driveStep(withHolds);
      instrValid = 1'b1;
      instr      = prog[idx];
      @(posedge gclk);
      if (stepEn) idx++;  // Accepted at this edge
      waited++;
    end
    if (idx < prog.size()) begin
      $display("Timed out feeding the program, %0d of %0d accepted", idx, prog.size());
      errors++;
    end
    waited = 0;
    while (expQ.size() != 0 && waited < 100) begin
      @(negedge gclk);
      driveStep(withHolds);
      instrValid = 1'b0;
      waited++;
    end
    if (expQ.size() != 0) begin
      $display("Timed out with %0d expected events never seen", expQ.size());
      errors++;
    end
    // Three stages, so four more edges flush any stray event
    repeat (4) begin
      @(negedge gclk);
      stepEn     = 1'b1;
      instrValid = 1'b0;
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testsRun++;
    if (errors == errBefore) begin
      $display("PASS  %s", name);
    end else begin
      testsFailed++;
      $display("FAIL  %s (%0d errors)", name, errors - errBefore);
    end
  endtask

  initial begin
    int errBefore;
    arstN       = 1'b0;
    stepEn      = 1'b0;
    instrValid  = 1'b0;
    instr       = '0;
    rngState    = 32'h76bc4baf;
    errors      = 0;
    checks      = 0;
    testsRun    = 0;
    testsFailed = 0;
    loadTests();
    errBefore = errors;
    applyReset();
    idleQuiet();
    reportTest("reset and idle pipeline stay quiet", errBefore);
    errBefore = errors;
    applyReset();
    runProgram(1'b0);
    reportTest("program with stepEn always high", errBefore);
    errBefore = errors;
    applyReset();
    runProgram(1'b1);
    reportTest("program with random stepEn holds", errBefore);
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checks, errors);
    if (errors == 0 && testsFailed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mbDecodeCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbcore_config.svh"

module mbDecodeCtrl
  import mbcore_pkg::*;
(
  input  logic                  gclk,
  input  logic                  arstN,
  input  logic                  stepEn,
  input  logic                  instrValid,
  input  logic [`MB_DATA_W-1:0] instr,
  input  fwdS                   exeDst,   // Destination now in execute
  input  fwdS                   resDst,   // Destination now in result
  output logic [`MB_REG_AW-1:0] rdAddrA,
  output logic [`MB_REG_AW-1:0] rdAddrB,
  output logic [`MB_REG_AW-1:0] rdAddrD,
  input  logic [`MB_DATA_W-1:0] rdDataA,
  input  logic [`MB_DATA_W-1:0] rdDataB,
  input  logic [`MB_DATA_W-1:0] rdDataD,
  output decCtrlS               dec
);

  logic [5:0]            opc;
  logic [`MB_REG_AW-1:0] rdF;
  logic [`MB_REG_AW-1:0] raF;
  logic [`MB_REG_AW-1:0] rbF;
  logic [10:0]           altF;
  mbOpE                  opNext;
  opSelE                 aSelNext;
  opSelE                 bSelNext;
  opSelE                 dSelNext;
  logic [`MB_DATA_W-1:0] immExt;

  assign {opc, rdF, raF, rbF, altF} = instr;

  // Immediate sits in the rb and alt fields
  assign immExt = {{(`MB_DATA_W - `MB_IMM_W){instr[`MB_IMM_W-1]}},
                   instr[`MB_IMM_W-1:0]};

  always_comb begin
    case (opc)
      6'h00, 6'h08: opNext = OP_ADD;
      6'h01, 6'h09: opNext = OP_RSUB;
      6'h20, 6'h28: opNext = OP_OR;
      6'h21, 6'h29: opNext = OP_AND;
      6'h22, 6'h2A: opNext = OP_XOR;
      6'h23, 6'h2B: opNext = OP_ANDN;
      6'h24: begin
        // Single-bit shifts, kind chosen by the low alt bits
        if (altF[6:0] == 7'h01) begin
          opNext = OP_SRA;
        end else if (altF[6:0] == 7'h41) begin
          opNext = OP_SRL;
        end else begin
          opNext = OP_NOP;
        end
      end
      6'h32, 6'h3A: opNext = OP_LOAD;   // LW, LWI
      6'h36, 6'h3E: opNext = OP_STORE;  // SW, SWI
      default:      opNext = OP_NOP;
    endcase
  end

  // Newest producer wins, r0 never forwards
  function automatic opSelE pickSrc(input logic [`MB_REG_AW-1:0] r,
                                    input fwdS nearDst,
                                    input fwdS farDst);
    opSelE sel;
    sel = SEL_REG;
    if (r != '0 && nearDst.valid && nearDst.regNum == r) begin
      sel = SEL_RES;
    end else if (r != '0 && farDst.valid && farDst.regNum == r) begin
      sel = SEL_LATE;
    end
    return sel;
  endfunction

  always_comb begin
    aSelNext = pickSrc(raF, exeDst, resDst);
    dSelNext = pickSrc(rdF, exeDst, resDst);
    if (opc[3]) begin
      bSelNext = SEL_IMM;
    end else begin
      bSelNext = pickSrc(rbF, exeDst, resDst);
    end
  end

  assign rdAddrA = raF;
  assign rdAddrB = rbF;
  assign rdAddrD = rdF;  // Store data source

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      dec <= '0;
    end else if (stepEn) begin
      dec.valid <= instrValid && (opNext != OP_NOP);
      dec.op    <= opNext;
      dec.rd    <= rdF;
      dec.aSel  <= aSelNext;
      dec.bSel  <= bSelNext;
      dec.dSel  <= dSelNext;
      dec.aData <= rdDataA;
      dec.bData <= rdDataB;
      dec.dData <= rdDataD;
      dec.imm   <= immExt;
    end
  end

  // A late select needs a write in the result stage at this same edge
  aLateNeedsWrite : assert property (
    @(posedge gclk) disable iff (!arstN)
    (stepEn && instrValid &&
     (aSelNext == SEL_LATE || bSelNext == SEL_LATE || dSelNext == SEL_LATE))
    |-> resDst.valid
  );

endmodule

`default_nettype wire

// ==== mbExecute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbcore_config.svh"

module mbExecute
  import mbcore_pkg::*;
(
  input  logic    gclk,
  input  logic    arstN,
  input  logic    stepEn,
  input  decCtrlS dec,
  input  fwdS     resFwd,   // Current result-stage value
  input  fwdS     lateFwd,  // Value written at the last enabled edge
  output fwdS     exeDst,
  output exeResS  exe
);

  logic [`MB_DATA_W-1:0] aOp;
  logic [`MB_DATA_W-1:0] bOp;
  logic [`MB_DATA_W-1:0] dOp;
  logic [`MB_DATA_W-1:0] sum;
  logic [`MB_DATA_W-1:0] aluOut;
  logic                  isLoad;
  logic                  isStore;

  function automatic logic [`MB_DATA_W-1:0] pickOperand(
    input opSelE                 sel,
    input logic [`MB_DATA_W-1:0] regVal,
    input logic [`MB_DATA_W-1:0] immVal,
    input logic [`MB_DATA_W-1:0] resVal,
    input logic [`MB_DATA_W-1:0] lateVal
  );
    logic [`MB_DATA_W-1:0] val;
    case (sel)
      SEL_RES:  val = resVal;
      SEL_LATE: val = lateVal;
      SEL_IMM:  val = immVal;
      default:  val = regVal;
    endcase
    return val;
  endfunction

  assign aOp = pickOperand(dec.aSel, dec.aData, dec.imm, resFwd.data, lateFwd.data);
  assign bOp = pickOperand(dec.bSel, dec.bData, dec.imm, resFwd.data, lateFwd.data);
  assign dOp = pickOperand(dec.dSel, dec.dData, dec.imm, resFwd.data, lateFwd.data);

  assign sum     = aOp + bOp;  // ADD result and byte address
  assign isLoad  = (dec.op == OP_LOAD);
  assign isStore = (dec.op == OP_STORE);

  always_comb begin
    case (dec.op)
      OP_ADD:  aluOut = sum;
      OP_RSUB: aluOut = bOp - aOp;
      OP_OR:   aluOut = aOp | bOp;
      OP_AND:  aluOut = aOp & bOp;
      OP_XOR:  aluOut = aOp ^ bOp;
      OP_ANDN: aluOut = aOp & ~bOp;
      OP_SRA:  aluOut = {aOp[`MB_DATA_W-1], aOp[`MB_DATA_W-1:1]};
      OP_SRL:  aluOut = {1'b0, aOp[`MB_DATA_W-1:1]};
      default: aluOut = sum;
    endcase
  end

  // In-flight destination for the forwarding compare in decode
  assign exeDst.valid  = dec.valid && !isStore && (dec.rd != '0);
  assign exeDst.regNum = dec.rd;
  assign exeDst.data   = aluOut;

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      exe <= '0;
    end else if (stepEn) begin
      exe.valid   <= dec.valid;
      exe.isLoad  <= dec.valid && isLoad;
      exe.isStore <= dec.valid && isStore;
      exe.rd      <= dec.rd;
      exe.value   <= isStore ? dOp : aluOut;
      exe.addr    <= sum[`MB_DMEM_AW+1:2];  // Byte address to word
    end
  end

  // A store never claims a destination
  aStoreNoDst : assert property (
    @(posedge gclk) disable iff (!arstN)
    (dec.valid && isStore) |-> !exeDst.valid
  );

endmodule

`default_nettype wire

// ==== mbRegFile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbcore_config.svh"

module mbRegFile (
  input  logic                  gclk,
  input  logic                  arstN,
  input  logic [`MB_REG_AW-1:0] rdAddrA,
  input  logic [`MB_REG_AW-1:0] rdAddrB,
  input  logic [`MB_REG_AW-1:0] rdAddrD,
  output logic [`MB_DATA_W-1:0] rdDataA,
  output logic [`MB_DATA_W-1:0] rdDataB,
  output logic [`MB_DATA_W-1:0] rdDataD,
  input  logic                  wrEn,
  input  logic [`MB_REG_AW-1:0] wrAddr,
  input  logic [`MB_DATA_W-1:0] wrData
);

  logic [`MB_DATA_W-1:0] regs [1:`MB_REG_N-1];  // r0 has no storage

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < `MB_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Reads of r0 return zero
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];
  assign rdDataD = (rdAddrD == '0) ? '0 : regs[rdAddrD];

  // Result stage must filter r0 writes before they get here
  aNoR0Write : assert property (
    @(posedge gclk) disable iff (!arstN)
    wrEn |-> wrAddr != '0
  );

endmodule

`default_nettype wire

// ==== mbResult.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mbcore_config.svh"

module mbResult
  import mbcore_pkg::*;
(
  input  logic                   gclk,
  input  logic                   arstN,
  input  logic                   stepEn,
  input  exeResS                 exe,
  output logic                   wrEn,
  output logic [`MB_REG_AW-1:0]  wrAddr,
  output logic [`MB_DATA_W-1:0]  wrData,
  output fwdS                    resFwd,
  output fwdS                    lateFwd,
  output logic                   wbValid,
  output logic [`MB_REG_AW-1:0]  wbReg,
  output logic [`MB_DATA_W-1:0]  wbData,
  output logic                   stValid,
  output logic [`MB_DMEM_AW-1:0] stAddr,
  output logic [`MB_DATA_W-1:0]  stData
);

  logic [`MB_DATA_W-1:0] dmem [0:`MB_DMEM_N-1];
  logic [`MB_DATA_W-1:0] loadData;
  logic                  writes;

  // Combinational read keeps loads at the same latency as ALU ops
  assign loadData = dmem[exe.addr];

  always_ff @(posedge gclk) begin
    if (stValid) begin
      dmem[exe.addr] <= exe.value;
    end
  end

  assign writes = exe.valid && !exe.isStore && (exe.rd != '0);
  assign wrAddr = exe.rd;
  assign wrData = exe.isLoad ? loadData : exe.value;
  assign wrEn   = stepEn && writes;  // Frozen pipeline writes nothing

  assign resFwd.valid  = writes;
  assign resFwd.regNum = exe.rd;
  assign resFwd.data   = wrData;

  always_ff @(posedge gclk or negedge arstN) begin
    if (!arstN) begin
      lateFwd <= '0;
    end else if (stepEn) begin
      lateFwd <= resFwd;
    end
  end

  // Observable events gated by the pipeline enable
  assign wbValid = wrEn;
  assign wbReg   = exe.rd;
  assign wbData  = wrData;
  assign stValid = stepEn && exe.valid && exe.isStore;
  assign stAddr  = exe.addr;
  assign stData  = exe.value;

  // Reported writes never name r0
  aWbNotR0 : assert property (
    @(posedge gclk) disable iff (!arstN)
    wbValid |-> (wbReg != '0)
  );

endmodule

`default_nettype wire

// ==== mbcore.f ====
+incdir+.
mbcore_pkg.sv
mbRegFile.sv
mbDecodeCtrl.sv
mbExecute.sv
mbResult.sv
mbCore.sv
mbCore_tb.sv

// ==== mbcore_config.svh ====
`ifndef MBCORE_CONFIG_SVH
`define MBCORE_CONFIG_SVH

// Core sizes for the three-stage integer pipeline

// Data path and register width
`define MB_DATA_W 32

// Register number width, 32 architectural registers
`define MB_REG_AW 5
`define MB_REG_N  (1 << `MB_REG_AW)

// Data memory word address width (64 words)
`define MB_DMEM_AW 6
`define MB_DMEM_N  (1 << `MB_DMEM_AW)

// Instruction immediate field width
`define MB_IMM_W 16

`endif

// ==== mbcore_pkg.sv ====
`default_nettype none

`include "mbcore_config.svh"

package mbcore_pkg;

  // Decoded operations, anything unknown is a NOP
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_RSUB  = 4'd2,
    OP_OR    = 4'd3,
    OP_AND   = 4'd4,
    OP_XOR   = 4'd5,
    OP_ANDN  = 4'd6,
    OP_SRA   = 4'd7,
    OP_SRL   = 4'd8,
    OP_LOAD  = 4'd9,
    OP_STORE = 4'd10
  } mbOpE;

  // Where an operand comes from in the execute cycle
  typedef enum logic [1:0] {
    SEL_REG  = 2'd0,  // Register file value read at decode
    SEL_RES  = 2'd1,  // Value now in the result stage
    SEL_LATE = 2'd2,  // Value written at the previous edge
    SEL_IMM  = 2'd3   // Sign-extended immediate
  } opSelE;

  // A pending or recent register write
  typedef struct packed {
    logic                  valid;
    logic [`MB_REG_AW-1:0] regNum;
    logic [`MB_DATA_W-1:0] data;
  } fwdS;

  // Decode to execute
  typedef struct packed {
    logic                  valid;  // Real operation, never set for NOP
    mbOpE                  op;
    logic [`MB_REG_AW-1:0] rd;     // Destination, or store source
    opSelE                 aSel;
    opSelE                 bSel;
    opSelE                 dSel;
    logic [`MB_DATA_W-1:0] aData;
    logic [`MB_DATA_W-1:0] bData;
    logic [`MB_DATA_W-1:0] dData;
    logic [`MB_DATA_W-1:0] imm;
  } decCtrlS;

  // Execute to result
  typedef struct packed {
    logic                   valid;
    logic                   isLoad;
    logic                   isStore;
    logic [`MB_REG_AW-1:0]  rd;
    logic [`MB_DATA_W-1:0]  value;  // ALU result or store data
    logic [`MB_DMEM_AW-1:0] addr;   // Word address
  } exeResS;

endpackage

`default_nettype wire

// ==== mbcore_tests.txt ====
# I <instruction word> | W <reg> <writeback value> | S <word addr> <store data>
# Expectations are listed in program order, all values in hex
I 20200005
W 01 00000005
I 2040FFFD
W 02 FFFFFFFD
I 00611000
W 03 00000002
I 04830800
W 04 00000003
I A0A400F0
W 05 000000F3
I A4C50031
W 06 00000031
I 88E62800
W 07 000000C2
I 8D053800
W 08 00000031
I 91420001
W 0A FFFFFFFE
I 916A0041
W 0B 7FFFFFFF
I 25A10064
W 0D 0000005F
I F9A00010
S 04 0000005F
I E9C00010
W 0E 0000005F
I 01EE0800
W 0F 00000064
I D9EF0000
S 19 00000064
I CA0F0000
W 10 00000064
I 20010007
I 02200800
W 11 00000005
I 42210800
I FA200020
S 08 00000005
